/* common/dcont_pkg.sv */
package dcont_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [16:0] immed_t;    // bit 16 is the extension bit.
  typedef logic [10:0] aluop_t;    // one-hot.
  typedef logic [3:0]  width_t;    // one-hot.
  typedef logic [3:0]  sela_t;
  typedef logic [2:0]  selbr_t;
  typedef logic [2:0]  selbi_t;
  typedef logic [2:0]  selc_t;

  localparam int IOP_ADD     = 0;
  localparam int IOP_SUB     = 1;
  localparam int IOP_AND     = 2;
  localparam int IOP_OR      = 3;
  localparam int IOP_XOR     = 4;
  localparam int IOP_NOR     = 5;
  localparam int IOP_SLTS    = 6;
  localparam int IOP_SLTU    = 7;
  localparam int IOP_SLEFT   = 8;
  localparam int IOP_SRIGHTL = 9;
  localparam int IOP_SRIGHTA = 10;

  localparam int W_NONE = 0;
  localparam int W_BYTE = 1;
  localparam int W_HALF = 2;
  localparam int W_WORD = 3;

  // primary opcodes.
  localparam logic [5:0] OP_SPECIAL = 6'h00;
  localparam logic [5:0] OP_REGIMM  = 6'h01;
  localparam logic [5:0] OP_J       = 6'h02;
  localparam logic [5:0] OP_JAL     = 6'h03;
  localparam logic [5:0] OP_BEQ     = 6'h04;
  localparam logic [5:0] OP_BNE     = 6'h05;
  localparam logic [5:0] OP_BLEZ    = 6'h06;
  localparam logic [5:0] OP_BGTZ    = 6'h07;
  localparam logic [5:0] OP_ADDI    = 6'h08;
  localparam logic [5:0] OP_ADDIU   = 6'h09;
  localparam logic [5:0] OP_SLTI    = 6'h0a;
  localparam logic [5:0] OP_SLTIU   = 6'h0b;
  localparam logic [5:0] OP_ANDI    = 6'h0c;
  localparam logic [5:0] OP_ORI     = 6'h0d;
  localparam logic [5:0] OP_XORI    = 6'h0e;
  localparam logic [5:0] OP_LUI     = 6'h0f;
  localparam logic [5:0] OP_LB      = 6'h20;
  localparam logic [5:0] OP_LH      = 6'h21;
  localparam logic [5:0] OP_LW      = 6'h23;
  localparam logic [5:0] OP_LBU     = 6'h24;
  localparam logic [5:0] OP_LHU     = 6'h25;
  localparam logic [5:0] OP_SB      = 6'h28;
  localparam logic [5:0] OP_SH      = 6'h29;
  localparam logic [5:0] OP_SW      = 6'h2b;

  // SPECIAL function field.
  localparam logic [5:0] FN_SLL     = 6'h00;
  localparam logic [5:0] FN_SRL     = 6'h02;
  localparam logic [5:0] FN_SRA     = 6'h03;
  localparam logic [5:0] FN_SLLV    = 6'h04;
  localparam logic [5:0] FN_SRLV    = 6'h06;
  localparam logic [5:0] FN_SRAV    = 6'h07;
  localparam logic [5:0] FN_JR      = 6'h08;
  localparam logic [5:0] FN_JALR    = 6'h09;
  localparam logic [5:0] FN_SYSCALL = 6'h0c;
  localparam logic [5:0] FN_BREAK   = 6'h0d;
  localparam logic [5:0] FN_ADD     = 6'h20;
  localparam logic [5:0] FN_ADDU    = 6'h21;
  localparam logic [5:0] FN_SUB     = 6'h22;
  localparam logic [5:0] FN_SUBU    = 6'h23;
  localparam logic [5:0] FN_AND     = 6'h24;
  localparam logic [5:0] FN_OR      = 6'h25;
  localparam logic [5:0] FN_XOR     = 6'h26;
  localparam logic [5:0] FN_NOR     = 6'h27;
  localparam logic [5:0] FN_SLT     = 6'h2a;
  localparam logic [5:0] FN_SLTU    = 6'h2b;

  localparam logic [4:0] RT_BLTZAL = 5'h10;
  localparam logic [4:0] RT_BGEZAL = 5'h11;

  localparam reg_addr_t REG_ZERO = 5'd0;
  localparam reg_addr_t REG_RA   = 5'd31;

  localparam sela_t SA_RESET   = 4'd0;
  localparam sela_t SA_DBUS    = 4'd1;
  localparam sela_t SA_HOLD    = 4'd2;
  localparam sela_t SA_IMMED   = 4'd3;
  localparam sela_t SA_PCREL   = 4'd4;
  localparam sela_t SA_ALURES  = 4'd5;
  localparam sela_t SA_ALUREGM = 4'd6;
  localparam sela_t SA_REGCWB  = 4'd7;
  localparam sela_t SA_REGASF  = 4'd8;

  localparam selbr_t SBR_RESET   = 3'd0;
  localparam selbr_t SBR_DBUS    = 3'd1;
  localparam selbr_t SBR_HOLD    = 3'd2;
  localparam selbr_t SBR_ALURES  = 3'd3;
  localparam selbr_t SBR_ALUREGM = 3'd4;
  localparam selbr_t SBR_REGCWB  = 3'd5;
  localparam selbr_t SBR_REGBSF  = 3'd6;

  localparam selbi_t SBI_RESET   = 3'd0;
  localparam selbi_t SBI_DBUS    = 3'd1;
  localparam selbi_t SBI_HOLD    = 3'd2;
  localparam selbi_t SBI_IMMED   = 3'd3;
  localparam selbi_t SBI_ALURES  = 3'd4;
  localparam selbi_t SBI_ALUREGM = 3'd5;
  localparam selbi_t SBI_REGCWB  = 3'd6;
  localparam selbi_t SBI_REGBSF  = 3'd7;

  localparam selc_t SC_RESET   = 3'd0;
  localparam selc_t SC_DBUS    = 3'd1;
  localparam selc_t SC_HOLD    = 3'd2;
  localparam selc_t SC_ALUREGM = 3'd3;

  typedef struct packed {
    reg_addr_t addr;
    logic      write;
  } dest_t;

  typedef struct packed {
    logic   dread;
    logic   dwrite;
    logic   dsign;
    logic   rdb_driver;
    width_t width;
  } mem_ctl_t;

  typedef struct packed {
    dest_t    dest;
    mem_ctl_t mem;
    selc_t    selc;
  } e_ctl_t;

endpackage

/* decode/dest_decode.sv */
`timescale 1ns/100ps

module dest_decode (
  input  dcont_pkg::inst_t     inst,
  output dcont_pkg::reg_addr_t rega_addr,
  output dcont_pkg::reg_addr_t regb_addr,
  output dcont_pkg::dest_t     dest
);

  import dcont_pkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;
  reg_addr_t  rs;
  reg_addr_t  rt;
  reg_addr_t  rd;
  reg_addr_t  dest_addr;
  logic       writes;

  assign opcode = inst[31:26];
  assign funct  = inst[5:0];
  assign rs     = inst[25:21];
  assign rt     = inst[20:16];
  assign rd     = inst[15:11];

  assign rega_addr = rs;
  assign regb_addr = rt;

  always_comb begin
    case (opcode)
      OP_SPECIAL: dest_addr = rd;
      OP_REGIMM,
      OP_JAL:     dest_addr = REG_RA;   // link register.
      default:    dest_addr = rt;
    endcase
  end

  always_comb begin
    case (opcode)
      OP_SPECIAL: writes = !(funct inside {FN_JR, FN_SYSCALL, FN_BREAK});
      OP_REGIMM:  writes = (rt == RT_BLTZAL) || (rt == RT_BGEZAL);
      OP_J:       writes = 1'b0;
      OP_BEQ,
      OP_BNE,
      OP_BLEZ,
      OP_BGTZ:    writes = 1'b0;
      OP_SB,
      OP_SH,
      OP_SW:      writes = 1'b0;
      default:    writes = 1'b1;   // unknown opcodes write rt.
    endcase
  end

  // r0 is never a real destination.
  assign dest = '{addr: dest_addr, write: writes && (dest_addr != REG_ZERO)};

endmodule

/* decode/alu_immed_decode.sv */
`timescale 1ns/100ps

module alu_immed_decode (
  input  dcont_pkg::inst_t  inst,
  output dcont_pkg::immed_t immed,
  output dcont_pkg::aluop_t aluop,
  output logic              sel_a_imm,
  output logic              sel_b_imm
);

  import dcont_pkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;
  logic [4:0] rt;

  assign opcode = inst[31:26];
  assign funct  = inst[5:0];
  assign rt     = inst[20:16];

  always_comb begin
    if (opcode inside {OP_ANDI, OP_ORI, OP_XORI})
      immed = {1'b0, inst[15:0]};   // logical ops zero-extend.
    else
      immed = {inst[15], inst[15:0]};
  end

  // sll, srl, sra take the shift amount from the immediate.
  assign sel_a_imm = (opcode == OP_SPECIAL) && (funct inside {FN_SLL, FN_SRL, FN_SRA});
  assign sel_b_imm = (inst[31:29] != 3'b000);

  always_comb begin
    aluop = '0;
    case (opcode)
      OP_SPECIAL:
        case (funct)
          FN_SLL, FN_SLLV:         aluop[IOP_SLEFT]   = 1'b1;
          FN_SRL, FN_SRLV:         aluop[IOP_SRIGHTL] = 1'b1;
          FN_SRA, FN_SRAV:         aluop[IOP_SRIGHTA] = 1'b1;
          FN_ADD, FN_ADDU,
          FN_JALR:                 aluop[IOP_ADD]     = 1'b1;   // link adds.
          FN_SUB, FN_SUBU:         aluop[IOP_SUB]     = 1'b1;
          FN_AND:                  aluop[IOP_AND]     = 1'b1;
          FN_OR:                   aluop[IOP_OR]      = 1'b1;
          FN_XOR:                  aluop[IOP_XOR]     = 1'b1;
          FN_NOR:                  aluop[IOP_NOR]     = 1'b1;
          FN_SLT:                  aluop[IOP_SLTS]    = 1'b1;
          FN_SLTU:                 aluop[IOP_SLTU]    = 1'b1;
          default:                 aluop[IOP_ADD]     = 1'b1;
        endcase
      OP_REGIMM:
        if ((rt == RT_BLTZAL) || (rt == RT_BGEZAL))
          aluop[IOP_ADD] = 1'b1;
        else
          aluop[IOP_XOR] = 1'b1;   // branch compare.
      OP_JAL,
      OP_ADDI,
      OP_ADDIU:                    aluop[IOP_ADD]     = 1'b1;
      OP_BEQ, OP_BNE,
      OP_BLEZ, OP_BGTZ:            aluop[IOP_XOR]     = 1'b1;
      OP_SLTI:                     aluop[IOP_SLTS]    = 1'b1;
      OP_SLTIU:                    aluop[IOP_SLTU]    = 1'b1;
      OP_ANDI:                     aluop[IOP_AND]     = 1'b1;
      OP_ORI:                      aluop[IOP_OR]      = 1'b1;
      OP_XORI:                     aluop[IOP_XOR]     = 1'b1;
      OP_LUI:                      aluop[IOP_SLEFT]   = 1'b1;   // shift by 16.
      default:                     aluop[IOP_ADD]     = 1'b1;
    endcase
  end

endmodule

/* decode/mem_ctl_decode.sv */
`timescale 1ns/100ps

module mem_ctl_decode (
  input  dcont_pkg::inst_t    inst,
  output dcont_pkg::mem_ctl_t mem,
  output dcont_pkg::selc_t    selc
);

  import dcont_pkg::*;

  logic [5:0] opcode;
  logic       is_load;
  logic       is_store;
  width_t     width;

  assign opcode   = inst[31:26];
  assign is_load  = opcode inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
  assign is_store = opcode inside {OP_SB, OP_SH, OP_SW};

  always_comb begin
    width = '0;
    case (opcode)
      OP_LB, OP_LBU, OP_SB: width[W_BYTE] = 1'b1;
      OP_LH, OP_LHU, OP_SH: width[W_HALF] = 1'b1;
      OP_LW, OP_SW:         width[W_WORD] = 1'b1;
      default:              width[W_NONE] = 1'b1;
    endcase
  end

  always_comb begin
    mem.dread      = is_load;
    mem.dwrite     = is_store;
    mem.dsign      = opcode inside {OP_LB, OP_LH};
    mem.rdb_driver = is_store;   // store data onto the bus.
    mem.width      = width;
  end

  // loaded data returns on the data bus.
  assign selc = is_load ? SC_DBUS : SC_ALUREGM;

endmodule

/* logic/ctl_pipe.sv */
`timescale 1ns/100ps

module ctl_pipe (
  input  logic                SYSCLK,
  input  logic                rst_n,
  input  logic                hold,
  input  logic                rls_hold,
  input  logic                xcpn,
  input  dcont_pkg::e_ctl_t   e_in,
  input  dcont_pkg::sela_t    sela,
  input  dcont_pkg::selbr_t   selbr,
  input  dcont_pkg::selbi_t   selbi,
  output dcont_pkg::mem_ctl_t mem_e,
  output dcont_pkg::dest_t    dest_e,
  output dcont_pkg::dest_t    dest_m,
  output dcont_pkg::dest_t    dest_w,
  output dcont_pkg::sela_t    sela_e,
  output dcont_pkg::selbr_t   selbr_e,
  output dcont_pkg::selbi_t   selbi_e,
  output dcont_pkg::selc_t    pselc_m,
  output logic                init_done
);

  import dcont_pkg::*;

  mem_ctl_t mem_e_r;
  selc_t    selc_e;
  logic     rdb_driver_m;

  always_ff @(posedge SYSCLK) begin
    if (!rst_n) begin
      dest_e       <= '0;
      mem_e_r      <= '0;
      selc_e       <= SC_ALUREGM;
      dest_m       <= '0;
      rdb_driver_m <= 1'b0;
      pselc_m      <= SC_ALUREGM;
      sela_e       <= SA_REGASF;
      selbr_e      <= SBR_REGBSF;
      selbi_e      <= SBI_REGBSF;
    end else if (!hold) begin
      dest_e.addr        <= e_in.dest.addr;
      dest_e.write       <= e_in.dest.write & ~xcpn;   // squash entering E.
      mem_e_r.dread      <= e_in.mem.dread & ~xcpn;
      mem_e_r.dwrite     <= e_in.mem.dwrite & ~xcpn;
      mem_e_r.dsign      <= e_in.mem.dsign;
      mem_e_r.rdb_driver <= e_in.mem.rdb_driver;
      mem_e_r.width      <= e_in.mem.width;
      selc_e             <= e_in.selc;
      dest_m.addr        <= dest_e.addr;
      dest_m.write       <= dest_e.write & ~xcpn;      // squash entering M.
      rdb_driver_m       <= mem_e_r.rdb_driver;
      pselc_m            <= selc_e;
      sela_e             <= sela;
      selbr_e            <= selbr;
      selbi_e            <= selbi;
    end
  end

  // W copy has its own hold.
  always_ff @(posedge SYSCLK) begin
    if (!rst_n)
      dest_w <= '0;
    else if (!rls_hold)
      dest_w <= dest_m;
  end

  always_ff @(posedge SYSCLK) begin
    if (!rst_n)
      init_done <= 1'b0;
    else
      init_done <= 1'b1;
  end

  // store driver lags the other strobes by one stage.
  assign mem_e = '{dread:      mem_e_r.dread,
                   dwrite:     mem_e_r.dwrite,
                   dsign:      mem_e_r.dsign,
                   rdb_driver: rdb_driver_m,
                   width:      mem_e_r.width};

endmodule

/* logic/bypass_select.sv */
`timescale 1ns/100ps

module bypass_select (
  input  dcont_pkg::reg_addr_t rega_addr,
  input  dcont_pkg::reg_addr_t regb_addr,
  input  logic                 sel_a_imm,
  input  logic                 sel_b_imm,
  input  dcont_pkg::dest_t     dest_e,
  input  dcont_pkg::dest_t     dest_m,
  input  dcont_pkg::dest_t     dest_w,
  input  dcont_pkg::sela_t     sela_e,
  input  dcont_pkg::selbr_t    selbr_e,
  input  dcont_pkg::selbi_t    selbi_e,
  input  dcont_pkg::selc_t     pselc_m,
  input  logic                 dload,
  input  logic                 hold,
  input  logic                 init_done,
  output dcont_pkg::sela_t     sela,
  output dcont_pkg::selbr_t    selbr,
  output dcont_pkg::selbi_t    selbi,
  output dcont_pkg::selc_t     selc
);

  import dcont_pkg::*;

  logic m_is_load;

  function automatic logic hit(reg_addr_t addr, dest_t dest);
    return dest.write && (dest.addr == addr);
  endfunction

  always_comb begin
    if (!init_done)  selc = SC_RESET;
    else if (dload)  selc = SC_DBUS;
    else if (hold)   selc = SC_HOLD;
    else             selc = pselc_m;
  end

  assign m_is_load = (selc == SC_DBUS);

  always_comb begin
    if (!init_done)                       sela = SA_RESET;
    else if (dload && sela_e == SA_DBUS)  sela = SA_DBUS;   // load data arriving.
    else if (hold)                        sela = SA_HOLD;
    else if (sel_a_imm)                   sela = SA_IMMED;
    else if (hit(rega_addr, dest_e))      sela = SA_ALURES;
    else if (hit(rega_addr, dest_m))      sela = m_is_load ? SA_DBUS : SA_ALUREGM;
    else if (hit(rega_addr, dest_w))      sela = SA_REGCWB;
    else                                  sela = SA_REGASF;
  end

  always_comb begin
    if (!init_done)                         selbr = SBR_RESET;
    else if (dload && selbr_e == SBR_DBUS)  selbr = SBR_DBUS;
    else if (hold)                          selbr = SBR_HOLD;
    else if (hit(regb_addr, dest_e))        selbr = SBR_ALURES;
    else if (hit(regb_addr, dest_m))        selbr = m_is_load ? SBR_DBUS : SBR_ALUREGM;
    else if (hit(regb_addr, dest_w))        selbr = SBR_REGCWB;
    else                                    selbr = SBR_REGBSF;
  end

  always_comb begin
    if (!init_done)                         selbi = SBI_RESET;
    else if (dload && selbi_e == SBI_DBUS)  selbi = SBI_DBUS;
    else if (hold)                          selbi = SBI_HOLD;
    else if (sel_b_imm)                     selbi = SBI_IMMED;
    else if (hit(regb_addr, dest_e))        selbi = SBI_ALURES;
    else if (hit(regb_addr, dest_m))        selbi = m_is_load ? SBI_DBUS : SBI_ALUREGM;
    else if (hit(regb_addr, dest_w))        selbi = SBI_REGCWB;
    else                                    selbi = SBI_REGBSF;
  end

endmodule

/* logic/dcont_top.sv */
`timescale 1ns/100ps

module dcont_top (
  input  logic                 SYSCLK,
  input  logic                 rst_n,
  input  dcont_pkg::inst_t     inst,
  input  logic                 hold,
  input  logic                 rls_hold,
  input  logic                 dload,
  input  logic                 xcpn,
  output dcont_pkg::immed_t    immed,
  output dcont_pkg::sela_t     sela,
  output dcont_pkg::selbr_t    selbr,
  output dcont_pkg::selbi_t    selbi,
  output dcont_pkg::aluop_t    aluop,
  output dcont_pkg::mem_ctl_t  mem,
  output dcont_pkg::selc_t     selc,
  output dcont_pkg::dest_t     regc,
  output dcont_pkg::reg_addr_t rega_addr,
  output dcont_pkg::reg_addr_t regb_addr
);

  import dcont_pkg::*;

  dest_t    dest_s;
  mem_ctl_t mem_s;
  selc_t    selc_s;
  e_ctl_t   e_in;
  logic     sel_a_imm;
  logic     sel_b_imm;
  dest_t    dest_e;
  dest_t    dest_w;
  sela_t    sela_e;
  selbr_t   selbr_e;
  selbi_t   selbi_e;
  selc_t    pselc_m;
  logic     init_done;

  assign e_in = '{dest: dest_s, mem: mem_s, selc: selc_s};

  dest_decode u_dest_decode (
    .inst      (inst),
    .rega_addr (rega_addr),
    .regb_addr (regb_addr),
    .dest      (dest_s)
  );

  alu_immed_decode u_alu_immed_decode (
    .inst      (inst),
    .immed     (immed),
    .aluop     (aluop),
    .sel_a_imm (sel_a_imm),
    .sel_b_imm (sel_b_imm)
  );

  mem_ctl_decode u_mem_ctl_decode (
    .inst (inst),
    .mem  (mem_s),
    .selc (selc_s)
  );

  // regc is the M copy of the destination.
  ctl_pipe u_ctl_pipe (
    .SYSCLK    (SYSCLK),
    .rst_n     (rst_n),
    .hold      (hold),
    .rls_hold  (rls_hold),
    .xcpn      (xcpn),
    .e_in      (e_in),
    .sela      (sela),
    .selbr     (selbr),
    .selbi     (selbi),
    .mem_e     (mem),
    .dest_e    (dest_e),
    .dest_m    (regc),
    .dest_w    (dest_w),
    .sela_e    (sela_e),
    .selbr_e   (selbr_e),
    .selbi_e   (selbi_e),
    .pselc_m   (pselc_m),
    .init_done (init_done)
  );

  bypass_select u_bypass_select (
    .rega_addr (rega_addr),
    .regb_addr (regb_addr),
    .sel_a_imm (sel_a_imm),
    .sel_b_imm (sel_b_imm),
    .dest_e    (dest_e),
    .dest_m    (regc),
    .dest_w    (dest_w),
    .sela_e    (sela_e),
    .selbr_e   (selbr_e),
    .selbi_e   (selbi_e),
    .pselc_m   (pselc_m),
    .dload     (dload),
    .hold      (hold),
    .init_done (init_done),
    .sela      (sela),
    .selbr     (selbr),
    .selbi     (selbi),
    .selc      (selc)
  );

endmodule

/* sim/dcont_tb.sv */
`timescale 1ns/100ps

module dcont_tb;

  import dcont_pkg::*;

  typedef struct packed {
    inst_t     inst;
    logic      hold;
    logic      rls_hold;
    logic      dload;
    logic      xcpn;
    reg_addr_t rega;
    reg_addr_t regb;
    immed_t    immed;
    aluop_t    aluop;
    sela_t     sela;
    selbr_t    selbr;
    selbi_t    selbi;
    selc_t     selc;
    mem_ctl_t  mem;
    dest_t     regc;
  } step_t;

  logic      SYSCLK;
  logic      rst_n;
  inst_t     inst;
  logic      hold;
  logic      rls_hold;
  logic      dload;
  logic      xcpn;
  immed_t    immed;
  sela_t     sela;
  selbr_t    selbr;
  selbi_t    selbi;
  aluop_t    aluop;
  mem_ctl_t  mem;
  selc_t     selc;
  dest_t     regc;
  reg_addr_t rega_addr;
  reg_addr_t regb_addr;

  step_t steps[$];
  int    cycles = 0;

  dcont_top DUT (
    .SYSCLK    (SYSCLK),
    .rst_n     (rst_n),
    .inst      (inst),
    .hold      (hold),
    .rls_hold  (rls_hold),
    .dload     (dload),
    .xcpn      (xcpn),
    .immed     (immed),
    .sela      (sela),
    .selbr     (selbr),
    .selbi     (selbi),
    .aluop     (aluop),
    .mem       (mem),
    .selc      (selc),
    .regc      (regc),
    .rega_addr (rega_addr),
    .regb_addr (regb_addr)
  );

  always #50 SYSCLK = ~SYSCLK;

  always @(posedge SYSCLK) begin
    cycles <= cycles + 1;
    if (cycles > steps.size() + 20) begin
      $display("Errors found");
      $fatal(1, "timeout: table did not finish within %0d cycles", steps.size() + 20);
    end
  end

  function automatic inst_t rtype(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, logic [5:0] fn);
    return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic inst_t itype(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                  logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // low half of an R-type word, sign-extended from rd[4].
  function automatic immed_t special_immed(reg_addr_t rd, logic [5:0] fn);
    return {rd[4], rd, 5'd0, fn};
  endfunction

  function automatic aluop_t alu_onehot(int pos);
    aluop_t v;
    v      = '0;
    v[pos] = 1'b1;
    return v;
  endfunction

  function automatic mem_ctl_t mem_strobes(logic rd, logic wr, logic sg, logic rdb, int w);
    width_t wd;
    wd    = '0;
    wd[w] = 1'b1;
    return '{dread: rd, dwrite: wr, dsign: sg, rdb_driver: rdb, width: wd};
  endfunction

  function automatic dest_t dest_of(reg_addr_t addr, logic write);
    return '{addr: addr, write: write};
  endfunction

  task automatic add_step(inst_t i, logic [3:0] ctl, reg_addr_t ra, reg_addr_t rb,
                          immed_t im, aluop_t op, sela_t sa, selbr_t sbr, selbi_t sbi,
                          selc_t sc, mem_ctl_t m, dest_t rc);
    step_t s;
    s = '{inst: i, hold: ctl[3], rls_hold: ctl[2], dload: ctl[1], xcpn: ctl[0],
          rega: ra, regb: rb, immed: im, aluop: op, sela: sa, selbr: sbr,
          selbi: sbi, selc: sc, mem: m, regc: rc};
    steps.push_back(s);
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    $display("Errors found");
    $fatal(1, "check of %s failed", name);
  endtask

  task automatic addr_matches(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic immed_matches(string name, immed_t got, immed_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic aluop_matches(string name, aluop_t got, aluop_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic sela_matches(string name, sela_t got, sela_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic selbr_matches(string name, selbr_t got, selbr_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic selbi_matches(string name, selbi_t got, selbi_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic selc_matches(string name, selc_t got, selc_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic mem_matches(string name, mem_ctl_t got, mem_ctl_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic regc_matches(string name, dest_t got, dest_t exp);
    if (got !== exp)
      report_mismatch(name, 32'(got), 32'(exp));
  endtask

  // ctl is {hold, rls_hold, dload, xcpn}; mem lags by one row, regc by two.
  task automatic build_steps();
    mem_ctl_t idle;
    idle = mem_strobes(1'b0, 1'b0, 1'b0, 1'b0, W_NONE);
    add_step(rtype(5'd1, 5'd2, 5'd3, FN_ADDU), 4'b0000, 5'd1, 5'd2, special_immed(5'd3, FN_ADDU),
             alu_onehot(IOP_ADD), SA_RESET, SBR_RESET, SBI_RESET, SC_RESET, '0, '0);
    add_step(rtype(5'd3, 5'd5, 5'd4, FN_SUBU), 4'b0000, 5'd3, 5'd5, special_immed(5'd4, FN_SUBU),
             alu_onehot(IOP_SUB), SA_ALURES, SBR_REGBSF, SBI_REGBSF, SC_ALUREGM, idle,
             dest_of(5'd0, 1'b0));
    add_step(rtype(5'd3, 5'd4, 5'd6, FN_AND), 4'b0000, 5'd3, 5'd4, special_immed(5'd6, FN_AND),
             alu_onehot(IOP_AND), SA_ALUREGM, SBR_ALURES, SBI_ALURES, SC_ALUREGM, idle,
             dest_of(5'd3, 1'b1));
    add_step(rtype(5'd3, 5'd4, 5'd7, FN_OR), 4'b0000, 5'd3, 5'd4, special_immed(5'd7, FN_OR),
             alu_onehot(IOP_OR), SA_REGCWB, SBR_ALUREGM, SBI_ALUREGM, SC_ALUREGM, idle,
             dest_of(5'd4, 1'b1));
    add_step(itype(OP_ADDI, 5'd10, 5'd9, 16'hfffd), 4'b0000, 5'd10, 5'd9, 17'h1fffd,
             alu_onehot(IOP_ADD), SA_REGASF, SBR_REGBSF, SBI_IMMED, SC_ALUREGM, idle,
             dest_of(5'd6, 1'b1));
    add_step(itype(OP_ANDI, 5'd9, 5'd11, 16'h8001), 4'b0000, 5'd9, 5'd11, 17'h08001,
             alu_onehot(IOP_AND), SA_ALURES, SBR_REGBSF, SBI_IMMED, SC_ALUREGM, idle,
             dest_of(5'd7, 1'b1));
    add_step(rtype(5'd0, 5'd13, 5'd12, FN_SLL), 4'b0000, 5'd0, 5'd13, special_immed(5'd12, FN_SLL),
             alu_onehot(IOP_SLEFT), SA_IMMED, SBR_REGBSF, SBI_REGBSF, SC_ALUREGM, idle,
             dest_of(5'd9, 1'b1));
    add_step(itype(OP_LUI, 5'd0, 5'd14, 16'h9abc), 4'b0000, 5'd0, 5'd14, 17'h19abc,
             alu_onehot(IOP_SLEFT), SA_REGASF, SBR_REGBSF, SBI_IMMED, SC_ALUREGM, idle,
             dest_of(5'd11, 1'b1));
    add_step(itype(OP_LW, 5'd16, 5'd15, 16'h0008), 4'b0000, 5'd16, 5'd15, 17'h00008,
             alu_onehot(IOP_ADD), SA_REGASF, SBR_REGBSF, SBI_IMMED, SC_ALUREGM, idle,
             dest_of(5'd12, 1'b1));
    add_step(rtype(5'd15, 5'd14, 5'd17, FN_ADDU), 4'b0000, 5'd15, 5'd14,
             special_immed(5'd17, FN_ADDU), alu_onehot(IOP_ADD), SA_ALURES, SBR_ALUREGM,
             SBI_ALUREGM, SC_ALUREGM, mem_strobes(1'b1, 1'b0, 1'b0, 1'b0, W_WORD),
             dest_of(5'd14, 1'b1));
    add_step(rtype(5'd15, 5'd17, 5'd18, FN_SUBU), 4'b0000, 5'd15, 5'd17,
             special_immed(5'd18, FN_SUBU), alu_onehot(IOP_SUB), SA_DBUS, SBR_ALURES,
             SBI_ALURES, SC_DBUS, idle, dest_of(5'd15, 1'b1));
    add_step(rtype(5'd20, 5'd21, 5'd19, FN_XOR), 4'b1010, 5'd20, 5'd21,
             special_immed(5'd19, FN_XOR), alu_onehot(IOP_XOR), SA_DBUS, SBR_HOLD, SBI_HOLD,
             SC_DBUS, idle, dest_of(5'd17, 1'b1));
    add_step(rtype(5'd20, 5'd21, 5'd19, FN_XOR), 4'b1000, 5'd20, 5'd21,
             special_immed(5'd19, FN_XOR), alu_onehot(IOP_XOR), SA_HOLD, SBR_HOLD, SBI_HOLD,
             SC_HOLD, idle, dest_of(5'd17, 1'b1));
    add_step(rtype(5'd20, 5'd21, 5'd19, FN_XOR), 4'b0000, 5'd20, 5'd21,
             special_immed(5'd19, FN_XOR), alu_onehot(IOP_XOR), SA_REGASF, SBR_REGBSF,
             SBI_REGBSF, SC_ALUREGM, idle, dest_of(5'd17, 1'b1));
    add_step(itype(OP_SW, 5'd23, 5'd22, 16'h0004), 4'b0000, 5'd23, 5'd22, 17'h00004,
             alu_onehot(IOP_ADD), SA_REGASF, SBR_REGBSF, SBI_IMMED, SC_ALUREGM, idle,
             dest_of(5'd18, 1'b1));
    add_step(itype(OP_SB, 5'd25, 5'd24, 16'h0000), 4'b1000, 5'd25, 5'd24, 17'h00000,
             alu_onehot(IOP_ADD), SA_HOLD, SBR_HOLD, SBI_HOLD, SC_HOLD,
             mem_strobes(1'b0, 1'b1, 1'b0, 1'b0, W_WORD), dest_of(5'd19, 1'b1));
    add_step(itype(OP_SB, 5'd25, 5'd24, 16'h0000), 4'b0000, 5'd25, 5'd24, 17'h00000,
             alu_onehot(IOP_ADD), SA_REGASF, SBR_REGBSF, SBI_IMMED, SC_ALUREGM,
             mem_strobes(1'b0, 1'b1, 1'b0, 1'b0, W_WORD), dest_of(5'd19, 1'b1));
    add_step(itype(OP_LB, 5'd27, 5'd26, 16'hffff), 4'b0000, 5'd27, 5'd26, 17'h1ffff,
             alu_onehot(IOP_ADD), SA_REGASF, SBR_REGBSF, SBI_IMMED, SC_ALUREGM,
             mem_strobes(1'b0, 1'b1, 1'b0, 1'b1, W_BYTE), dest_of(5'd22, 1'b0));
    add_step(itype(OP_LHU, 5'd29, 5'd28, 16'h0002), 4'b0001, 5'd29, 5'd28, 17'h00002,
             alu_onehot(IOP_ADD), SA_REGASF, SBR_REGBSF, SBI_IMMED, SC_ALUREGM,
             mem_strobes(1'b1, 1'b0, 1'b1, 1'b1, W_BYTE), dest_of(5'd24, 1'b0));
    add_step(rtype(5'd26, 5'd28, 5'd30, FN_ADDU), 4'b0000, 5'd26, 5'd28,
             special_immed(5'd30, FN_ADDU), alu_onehot(IOP_ADD), SA_REGASF, SBR_REGBSF,
             SBI_REGBSF, SC_DBUS, mem_strobes(1'b0, 1'b0, 1'b0, 1'b0, W_HALF),
             dest_of(5'd26, 1'b0));
    add_step(itype(OP_BEQ, 5'd1, 5'd2, 16'h0010), 4'b0000, 5'd1, 5'd2, 17'h00010,
             alu_onehot(IOP_XOR), SA_REGASF, SBR_REGBSF, SBI_REGBSF, SC_DBUS, idle,
             dest_of(5'd28, 1'b0));
    add_step(itype(OP_JAL, 5'd0, 5'd0, 16'h0100), 4'b0000, 5'd0, 5'd0, 17'h00100,
             alu_onehot(IOP_ADD), SA_REGASF, SBR_REGBSF, SBI_REGBSF, SC_ALUREGM, idle,
             dest_of(5'd30, 1'b1));
    add_step(itype(OP_ADDIU, 5'd31, 5'd0, 16'h0001), 4'b0100, 5'd31, 5'd0, 17'h00001,
             alu_onehot(IOP_ADD), SA_ALURES, SBR_REGBSF, SBI_IMMED, SC_ALUREGM, idle,
             dest_of(5'd2, 1'b0));
    add_step(rtype(5'd30, 5'd31, 5'd5, FN_OR), 4'b0000, 5'd30, 5'd31, special_immed(5'd5, FN_OR),
             alu_onehot(IOP_OR), SA_REGCWB, SBR_ALUREGM, SBI_ALUREGM, SC_ALUREGM, idle,
             dest_of(5'd31, 1'b1));
    add_step(itype(OP_REGIMM, 5'd4, RT_BGEZAL, 16'h0004), 4'b0000, 5'd4, RT_BGEZAL, 17'h00004,
             alu_onehot(IOP_ADD), SA_REGASF, SBR_REGBSF, SBI_REGBSF, SC_ALUREGM, idle,
             dest_of(5'd0, 1'b0));
    add_step(itype(OP_REGIMM, 5'd6, 5'd0, 16'h8000), 4'b0000, 5'd6, 5'd0, 17'h18000,
             alu_onehot(IOP_XOR), SA_REGASF, SBR_REGBSF, SBI_REGBSF, SC_ALUREGM, idle,
             dest_of(5'd5, 1'b1));
    add_step(rtype(5'd0, 5'd0, 5'd0, FN_SLL), 4'b0000, 5'd0, 5'd0, special_immed(5'd0, FN_SLL),
             alu_onehot(IOP_SLEFT), SA_IMMED, SBR_REGBSF, SBI_REGBSF, SC_ALUREGM, idle,
             dest_of(5'd31, 1'b1));
    add_step(rtype(5'd0, 5'd0, 5'd0, FN_SLL), 4'b0000, 5'd0, 5'd0, special_immed(5'd0, FN_SLL),
             alu_onehot(IOP_SLEFT), SA_IMMED, SBR_REGBSF, SBI_REGBSF, SC_ALUREGM, idle,
             dest_of(5'd31, 1'b0));
    add_step(rtype(5'd0, 5'd0, 5'd0, FN_SLL), 4'b0000, 5'd0, 5'd0, special_immed(5'd0, FN_SLL),
             alu_onehot(IOP_SLEFT), SA_IMMED, SBR_REGBSF, SBI_REGBSF, SC_ALUREGM, idle,
             dest_of(5'd0, 1'b0));
  endtask

  initial begin
    step_t      s;
    inst_t      word;
    immed_t     exp_immed;
    logic [4:0] shamt;
    SYSCLK   = 1'b0;
    rst_n    = 1'b0;
    inst     = '0;
    hold     = 1'b0;
    rls_hold = 1'b0;
    dload    = 1'b0;
    xcpn     = 1'b0;
    void'($urandom(16473));
    build_steps();
    repeat (3) @(posedge SYSCLK);
    #10;
    rst_n = 1'b1;
    for (int n = 0; n < steps.size(); n++) begin
      if (n > 0) begin
        @(posedge SYSCLK);
        #10;
      end
      s         = steps[n];
      word      = s.inst;
      exp_immed = s.immed;
      if (word[31:26] == OP_SPECIAL) begin
        shamt           = 5'($urandom());
        word[10:6]      = shamt;   // shamt shows up in the immediate.
        exp_immed[10:6] = shamt;
      end
      inst     = word;
      hold     = s.hold;
      rls_hold = s.rls_hold;
      dload    = s.dload;
      xcpn     = s.xcpn;
      #80;
      addr_matches("rega_addr", rega_addr, s.rega);
      addr_matches("regb_addr", regb_addr, s.regb);
      immed_matches("immed", immed, exp_immed);
      aluop_matches("aluop", aluop, s.aluop);
      sela_matches("sela", sela, s.sela);
      selbr_matches("selbr", selbr, s.selbr);
      selbi_matches("selbi", selbi, s.selbi);
      selc_matches("selc", selc, s.selc);
      mem_matches("mem", mem, s.mem);
      regc_matches("regc", regc, s.regc);
    end
    $display("No errors");
    $finish;
  end

endmodule

/* sim.f */
common/dcont_pkg.sv
decode/dest_decode.sv
decode/alu_immed_decode.sv
decode/mem_ctl_decode.sv
logic/ctl_pipe.sv
logic/bypass_select.sv
logic/dcont_top.sv
sim/dcont_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dcont_tb
RTL_TOP   ?= dcont_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
